/* src/mem_pkg.sv */
package mem_pkg;

    // bus geometry.
    localparam int unsigned line_width       = 256;                    // cache line in bits.
    localparam int unsigned beat_width       = 64;                     // burst bus word.
    localparam int unsigned beats_per_line   = line_width / beat_width;
    localparam int unsigned addr_width       = 32;                     // byte address.
    localparam int unsigned line_offset_bits = $clog2(line_width / 8); // byte offset in a line.

    // line request from a cache, or from the arbiter into the adapter.
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [line_width-1:0] wdata;
    } line_req_t;

    // answer to a line request.
    typedef struct packed {
        logic                  resp;   // one-cycle completion pulse.
        logic [line_width-1:0] rdata;
    } line_rsp_t;

    // adapter request on the outside memory bus.
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;   // line-aligned.
        logic [beat_width-1:0] wdata;  // current write beat.
    } burst_req_t;

    // memory answer, one resp per beat.
    typedef struct packed {
        logic                  resp;
        logic [beat_width-1:0] rdata;
    } burst_rsp_t;

    // arbiter owner.
    typedef enum logic [1:0] {
        arb_idle,
        arb_icache,
        arb_dcache
    } arb_state_e;

    // adapter burst sequencing.
    typedef enum logic [1:0] {
        ad_idle,
        ad_read,
        ad_write,
        ad_done
    } adapter_state_e;

endpackage : mem_pkg

/* src/line_arbiter.sv */
`timescale 1ns/10ps

module line_arbiter
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction cache side.
    input  line_req_t icache_req,
    output line_rsp_t icache_rsp,

    // data cache side.
    input  line_req_t dcache_req,
    output line_rsp_t dcache_rsp,

    // toward the cacheline adapter.
    output line_req_t pmem_req,
    input  line_rsp_t pmem_rsp
);

    arb_state_e state;
    arb_state_e next_state;
    logic       icache_pending;
    logic       dcache_pending;

    assign icache_pending = icache_req.read | icache_req.write;
    assign dcache_pending = dcache_req.read | dcache_req.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

    // owner is kept until its request drops.
    always_comb begin
        next_state = state;
        unique case (state)
            arb_idle: begin
                if (icache_pending) begin
                    next_state = arb_icache;     // icache wins a tie.
                end else if (dcache_pending) begin
                    next_state = arb_dcache;
                end
            end
            arb_icache: begin
                if (!icache_pending) begin
                    if (dcache_pending) begin
                        next_state = arb_dcache; // direct hand-over.
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_dcache: begin
                if (!dcache_pending) begin
                    if (icache_pending) begin
                        next_state = arb_icache;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            default: next_state = arb_idle;
        endcase
    end

    // routing follows the registered owner, same cycle.
    always_comb begin
        pmem_req   = '0;
        icache_rsp = '0;
        dcache_rsp = '0;
        unique case (state)
            arb_icache: begin
                pmem_req   = icache_req;
                icache_rsp = pmem_rsp;
            end
            arb_dcache: begin
                pmem_req   = dcache_req;
                dcache_rsp = pmem_rsp;
            end
            default: begin
                pmem_req = '0;                   // nobody owns the path.
            end
        endcase
    end

    // only the owner ever sees a completion.
    a_rsp_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !(icache_rsp.resp && dcache_rsp.resp)
    ) else $error("line_arbiter: both caches got resp in one cycle");

    a_icache_rw_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(icache_req.read && icache_req.write)
    ) else $error("line_arbiter: icache raised read and write together");

    a_dcache_rw_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(dcache_req.read && dcache_req.write)
    ) else $error("line_arbiter: dcache raised read and write together");

endmodule : line_arbiter

/* src/cacheline_adapter.sv */
`timescale 1ns/10ps

module cacheline_adapter
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // line side, from the arbiter.
    input  line_req_t  line_req,
    output line_rsp_t  line_rsp,

    // burst side, to the outside memory.
    output burst_req_t mem_req,
    input  burst_rsp_t mem_rsp
);

    adapter_state_e        state;
    adapter_state_e        next_state;
    logic [1:0]            beat_cnt;   // current beat within the line.
    logic [addr_width-1:0] addr_q;     // line-aligned address of the transfer.
    logic [line_width-1:0] line_buf;   // write source or read assembly.
    logic                  accept;
    logic                  beat_done;
    logic                  last_beat;

    // a new line is taken only from idle.
    assign accept    = (state == ad_idle) && (line_req.read || line_req.write);
    assign beat_done = ((state == ad_read) || (state == ad_write)) && mem_rsp.resp;
    assign last_beat = beat_done && (beat_cnt == 2'(beats_per_line - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ad_idle;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (beat_done) begin
                beat_cnt <= beat_cnt + 2'd1; // wraps to zero after the last beat.
            end
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            ad_idle: begin
                if (line_req.write) begin
                    next_state = ad_write;
                end else if (line_req.read) begin
                    next_state = ad_read;
                end
            end
            ad_read: begin
                if (last_beat) begin
                    next_state = ad_done;
                end
            end
            ad_write: begin
                if (last_beat) begin
                    next_state = ad_done;
                end
            end
            ad_done: begin
                next_state = ad_idle;        // requester drops in this cycle.
            end
            default: next_state = ad_idle;
        endcase
    end

    // payload registers.
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {line_req.addr[addr_width-1:line_offset_bits],
                       {line_offset_bits{1'b0}}};
            if (line_req.write) begin
                line_buf <= line_req.wdata;
            end
        end else if ((state == ad_read) && mem_rsp.resp) begin
            line_buf[beat_cnt*beat_width +: beat_width] <= mem_rsp.rdata;
        end
    end

    always_comb begin
        mem_req.read  = (state == ad_read);
        mem_req.write = (state == ad_write);
        mem_req.addr  = addr_q;
        mem_req.wdata = line_buf[beat_cnt*beat_width +: beat_width];
    end

    // completion, with the assembled line on a read.
    always_comb begin
        line_rsp.resp  = (state == ad_done);
        line_rsp.rdata = line_buf;
    end

    a_cnt_idle_hold: assert property (
        @(posedge clk) disable iff (rst)
        (state == ad_idle) |=> $stable(beat_cnt)
    ) else $error("cacheline_adapter: beat counter moved while idle");

    a_resp_pulse: assert property (
        @(posedge clk) disable iff (rst)
        line_rsp.resp |=> !line_rsp.resp
    ) else $error("cacheline_adapter: line resp held longer than one cycle");

    a_burst_rw_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write)
    ) else $error("cacheline_adapter: burst read and write both high");

endmodule : cacheline_adapter

/* src/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // instruction cache port.
    input  line_req_t  icache_req,
    output line_rsp_t  icache_rsp,

    // data cache port.
    input  line_req_t  dcache_req,
    output line_rsp_t  dcache_rsp,

    // outside burst memory bus.
    output burst_req_t mem_req,
    input  burst_rsp_t mem_rsp
);

    line_req_t pmem_req;   // owner's line request.
    line_rsp_t pmem_rsp;   // adapter completion.

    // picks which cache owns the memory path.
    line_arbiter i_line_arbiter (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_req),
        .icache_rsp (icache_rsp),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp),
        .pmem_req   (pmem_req),
        .pmem_rsp   (pmem_rsp)
    );

    // line to four-beat burst conversion.
    cacheline_adapter i_cacheline_adapter (
        .clk      (clk),
        .rst      (rst),
        .line_req (pmem_req),
        .line_rsp (pmem_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

endmodule : mem_subsystem

/* testbench/burst_mem_model.sv */
`timescale 1ns/10ps

module burst_mem_model
    import mem_pkg::*;
(
    input  logic       clk,
    input  burst_req_t mem_req,
    output burst_rsp_t mem_rsp
);

    logic [beat_width-1:0] words [logic [addr_width-1:0]]; // sparse, keyed by byte address.
    int unsigned           beat;                            // beat position in the burst.
    int unsigned           stall;                           // idle cycles before the next beat.

    // untouched words read as a pattern of their own address.
    function automatic logic [beat_width-1:0] fill_word(input logic [addr_width-1:0] a);
        return {a, a ^ 32'h5a5a_5a5a};
    endfunction

    initial begin
        mem_rsp = '0;
        beat    = 0;
        stall   = 0;
    end

    // one decision per falling edge, taken by the adapter at the next rising edge.
    always @(negedge clk) begin
        logic [addr_width-1:0] word_addr;
        burst_rsp_t            next_rsp;
        if (mem_rsp.resp) begin
            beat = beat + 1;                  // previous beat was consumed.
        end
        next_rsp = '0;
        if (!(mem_req.read || mem_req.write)) begin
            beat = 0;                         // no burst in progress.
        end else if (stall != 0) begin
            stall = stall - 1;
        end else begin
            word_addr = mem_req.addr + (32'(beat) << 3);
            if (mem_req.write) begin
                words[word_addr] = mem_req.wdata;
            end else if (words.exists(word_addr)) begin
                next_rsp.rdata = words[word_addr];
            end else begin
                next_rsp.rdata = fill_word(word_addr);
            end
            next_rsp.resp = 1'b1;
            stall         = $urandom_range(3, 0);
        end
        mem_rsp = next_rsp;
    end

endmodule : burst_mem_model

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/10ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int timeout_cycles = 200;

    logic       clk;
    logic       rst;
    line_req_t  icache_req;
    line_req_t  dcache_req;
    line_rsp_t  icache_rsp;
    line_rsp_t  dcache_rsp;
    burst_req_t mem_req;
    burst_rsp_t mem_rsp;

    logic [line_width-1:0] ref_store [logic [addr_width-line_offset_bits-1:0]];
    burst_req_t            last_burst;  // last active request on the burst bus.
    bit                    in_burst;    // burst bus was active in the previous cycle.
    int                    beats_seen;  // beats since the last line completion.
    int                    error_count;
    int                    timeout_count;
    bit                    done_order[$]; // 0 is icache and 1 is dcache.

    mem_subsystem i_mem_subsystem (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_req),
        .icache_rsp (icache_rsp),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    burst_mem_model i_burst_mem_model (
        .clk     (clk),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 clk = ~clk;

    // expected line from written data or the memory's address pattern.
    function automatic logic [line_width-1:0] ref_line(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] w;
        logic [line_width-1:0] line;
        if (ref_store.exists(addr[addr_width-1:line_offset_bits])) begin
            return ref_store[addr[addr_width-1:line_offset_bits]];
        end
        for (int i = 0; i < line_width / beat_width; i++) begin
            w = {addr[addr_width-1:line_offset_bits], {line_offset_bits{1'b0}}} + 32'(i * 8);
            line[i*beat_width +: beat_width] = {w, w ^ 32'h5a5a_5a5a};
        end
        return line;
    endfunction

    function automatic logic [addr_width-1:0] rand_addr();
        return 32'h0040_0000 | (32'($urandom_range(15, 0)) << 5) | 32'($urandom_range(31, 0));
    endfunction

    function automatic logic [line_width-1:0] rand_line();
        logic [line_width-1:0] v;
        v = '0;
        repeat (line_width / 32) begin
            v = {v[line_width-33:0], $urandom()};
        end
        return v;
    endfunction

    task automatic check_line_rsp(input string name, input line_rsp_t got, input line_rsp_t exp);
        if (got.resp !== exp.resp) begin
            $display("[FAIL] t=%0t %s.resp: got %b, expected %b",
                     $time, name, got.resp, exp.resp);
            error_count = error_count + 1;
        end else if (exp.resp && got.rdata !== exp.rdata) begin
            $display("[FAIL] t=%0t %s.rdata: got %h, expected %h",
                     $time, name, got.rdata, exp.rdata);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_mem_req(input string field, input burst_req_t got,
                                 input burst_req_t exp);
        logic [addr_width-1:0] g;
        logic [addr_width-1:0] e;
        if (field == "read") begin
            g = 32'(got.read);
            e = 32'(exp.read);
        end else if (field == "write") begin
            g = 32'(got.write);
            e = 32'(exp.write);
        end else begin
            g = got.addr;
            e = exp.addr;
        end
        if (g !== e) begin
            $display("[FAIL] t=%0t mem_req.%s: got %h, expected %h", $time, field, g, e);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_reset_state();
        check_line_rsp("icache_rsp", icache_rsp, '0);
        check_line_rsp("dcache_rsp", dcache_rsp, '0);
        check_mem_req("read", mem_req, '0);
        check_mem_req("write", mem_req, '0);
    endtask

    // a finished line checks the burst shape and then the data or the reference.
    task automatic check_completion(input bit port, input line_req_t req, input line_rsp_t rsp);
        burst_req_t exp_burst;
        line_rsp_t  exp_rsp;
        exp_burst       = '0;
        exp_burst.read  = req.read;
        exp_burst.write = req.write;
        exp_burst.addr  = req.addr & ~32'(line_width / 8 - 1);
        check_mem_req("addr", last_burst, exp_burst);
        check_mem_req("read", last_burst, exp_burst);
        check_mem_req("write", last_burst, exp_burst);
        check_count("beats per line", beats_seen, 4);
        beats_seen = 0;
        if (req.write) begin
            ref_store[req.addr[addr_width-1:line_offset_bits]] = req.wdata;
        end else begin
            exp_rsp.resp  = 1'b1;
            exp_rsp.rdata = ref_line(req.addr);
            check_line_rsp(port ? "dcache_rsp" : "icache_rsp", rsp, exp_rsp);
        end
        done_order.push_back(port);
    endtask

    // compares completions and tracks the burst bus on the rising edge.
    always @(posedge clk) begin
        if (!rst && icache_rsp.resp === 1'b1) begin
            check_completion(1'b0, icache_req, icache_rsp);
        end
        if (!rst && dcache_rsp.resp === 1'b1) begin
            check_completion(1'b1, dcache_req, dcache_rsp);
        end
        if (!rst && (mem_req.read || mem_req.write)) begin
            if (in_burst) begin
                check_mem_req("addr", mem_req, last_burst);  // held for the whole burst.
                check_mem_req("read", mem_req, last_burst);
                check_mem_req("write", mem_req, last_burst);
            end
            last_burst = mem_req;
            in_burst   = 1'b1;
            if (mem_rsp.resp) begin
                beats_seen = beats_seen + 1;
            end
        end else begin
            in_burst = 1'b0;
        end
    end

    task automatic icache_access(input logic wr, input logic [addr_width-1:0] addr,
                                 input logic [line_width-1:0] data);
        int   waited;
        logic done;
        @(negedge clk);
        icache_req.read  = !wr;
        icache_req.write = wr;
        icache_req.addr  = addr;
        icache_req.wdata = data;
        waited = 0;
        do begin
            @(posedge clk);
            done   = icache_rsp.resp;
            waited = waited + 1;
        end while (done !== 1'b1 && waited < timeout_cycles);
        if (done !== 1'b1) begin
            $display("timeout: the instruction cache port saw no response to its request");
            timeout_count = timeout_count + 1;
        end
        @(negedge clk);
        icache_req = '0;                      // low for at least one cycle.
    endtask

    task automatic dcache_access(input logic wr, input logic [addr_width-1:0] addr,
                                 input logic [line_width-1:0] data);
        int   waited;
        logic done;
        @(negedge clk);
        dcache_req.read  = !wr;
        dcache_req.write = wr;
        dcache_req.addr  = addr;
        dcache_req.wdata = data;
        waited = 0;
        do begin
            @(posedge clk);
            done   = dcache_rsp.resp;
            waited = waited + 1;
        end while (done !== 1'b1 && waited < timeout_cycles);
        if (done !== 1'b1) begin
            $display("timeout: the data cache port saw no response to its request");
            timeout_count = timeout_count + 1;
        end
        @(negedge clk);
        dcache_req = '0;
    endtask

    task automatic random_traffic(input bit on_dcache, input int count);
        logic                  wr;
        logic [addr_width-1:0] addr;
        logic [line_width-1:0] data;
        repeat (count) begin
            wr   = 1'($urandom_range(1, 0));
            addr = rand_addr();
            data = rand_line();
            if (on_dcache) begin
                dcache_access(wr, addr, data);
            end else begin
                icache_access(wr, addr, data);
            end
        end
    endtask

    initial begin
        logic [addr_width-1:0] line_a;
        logic [line_width-1:0] data_a;
        void'($urandom(32'h99c268ec));
        clk           = 1'b0;
        rst           = 1'b1;
        icache_req    = '0;
        dcache_req    = '0;
        error_count   = 0;
        timeout_count = 0;
        beats_seen    = 0;
        last_burst    = '0;
        in_burst      = 1'b0;

        @(posedge clk);                       // state is unknown before the first edge.
        repeat (3) begin
            @(posedge clk);
            check_reset_state();
        end
        @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_reset_state();
        end

        line_a = rand_addr();
        data_a = rand_line();
        dcache_access(1'b1, line_a, data_a);
        dcache_access(1'b0, line_a, '0);
        icache_access(1'b0, line_a, '0);
        icache_access(1'b0, line_a ^ 32'h0000_1000, '0); // never written.

        // simultaneous start from idle and back-to-back traffic on both ports.
        done_order.delete();
        fork
            repeat (4) icache_access(1'b0, rand_addr(), '0);
            repeat (4) dcache_access(1'b0, rand_addr(), '0);
        join
        if (done_order.size() != 8) begin
            $display("back-to-back run finished %0d lines instead of 8", done_order.size());
            error_count = error_count + 1;
        end else begin
            if (done_order[0] != 1'b0) begin
                $display("the instruction cache was not served first on a tied request");
                error_count = error_count + 1;
            end
            for (int k = 1; k < 8; k++) begin
                if (done_order[k] == done_order[k-1]) begin
                    $display("one port was served twice in a row while the other waited");
                    error_count = error_count + 1;
                end
            end
        end

        fork
            random_traffic(1'b0, 20);
            random_traffic(1'b1, 20);
        join

        $display("run finished: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

/* files.f */
src/mem_pkg.sv
src/line_arbiter.sv
src/cacheline_adapter.sv
src/mem_subsystem.sv
testbench/burst_mem_model.sv
testbench/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  # design, package first
  - files:
      - src/mem_pkg.sv
      - src/line_arbiter.sv
      - src/cacheline_adapter.sv
      - src/mem_subsystem.sv

  # simulation only
  - target: test
    files:
      - testbench/burst_mem_model.sv
      - testbench/tb_mem_subsystem.sv
